// ==== verilog/exec_pkg.sv ====
package exec_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [4:0] {
        EX_NOP,
        EX_ADD, EX_SUB, EX_SLT, EX_SLTU,
        EX_NOR, EX_AND, EX_OR, EX_XOR,
        EX_SLL, EX_SRL, EX_SRA,
        EX_MUL, EX_MULH, EX_MULHU,
        EX_DIV, EX_MOD, EX_DIVU, EX_MODU
    } ex_op_e;

    // inst[31:15] of the 3R group
    localparam logic [16:0] OPC3R_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC3R_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC3R_SLT     = 17'h00024;
    localparam logic [16:0] OPC3R_SLTU    = 17'h00025;
    localparam logic [16:0] OPC3R_NOR     = 17'h00028;
    localparam logic [16:0] OPC3R_AND     = 17'h00029;
    localparam logic [16:0] OPC3R_OR      = 17'h0002A;
    localparam logic [16:0] OPC3R_XOR     = 17'h0002B;
    localparam logic [16:0] OPC3R_SLL_W   = 17'h0002E;
    localparam logic [16:0] OPC3R_SRL_W   = 17'h0002F;
    localparam logic [16:0] OPC3R_SRA_W   = 17'h00030;
    localparam logic [16:0] OPC3R_MUL_W   = 17'h00038;
    localparam logic [16:0] OPC3R_MULH_W  = 17'h00039;
    localparam logic [16:0] OPC3R_MULH_WU = 17'h0003A;
    localparam logic [16:0] OPC3R_DIV_W   = 17'h00040;
    localparam logic [16:0] OPC3R_MOD_W   = 17'h00041;
    localparam logic [16:0] OPC3R_DIV_WU  = 17'h00042;
    localparam logic [16:0] OPC3R_MOD_WU  = 17'h00043;

    // inst[31:22] of the 2RI12 group
    localparam logic [9:0] OPC2RI12_SLTI   = 10'h008;
    localparam logic [9:0] OPC2RI12_SLTUI  = 10'h009;
    localparam logic [9:0] OPC2RI12_ADDI_W = 10'h00A;
    localparam logic [9:0] OPC2RI12_ANDI   = 10'h00D;
    localparam logic [9:0] OPC2RI12_ORI    = 10'h00E;
    localparam logic [9:0] OPC2RI12_XORI   = 10'h00F;

    typedef struct packed {
        logic [16:0] opcode;
        reg_addr_t   rk;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_3r_s;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_2ri12_s;

    typedef union packed {
        fmt_3r_s    r3;
        fmt_2ri12_s ri12;
    } inst_u;

    function automatic logic is_mdu_op(input ex_op_e op);
        return op inside {EX_MUL, EX_MULH, EX_MULHU, EX_DIV, EX_MOD, EX_DIVU, EX_MODU};
    endfunction

endpackage

// ==== verilog/stage_if.sv ====
`timescale 1ns/1ps

interface dec_ex_if import exec_pkg::*; ();
    logic      valid;
    ex_op_e    op;
    data_t     opnd1;
    data_t     opnd2;
    reg_addr_t rd;
    logic      illegal;

    modport dec (output valid, op, opnd1, opnd2, rd, illegal);
    modport ex  (input  valid, op, opnd1, opnd2, rd, illegal);
endinterface

interface ex_res_if import exec_pkg::*; ();
    logic      valid;
    reg_addr_t rd;
    data_t     data;
    logic      illegal;

    modport ex  (output valid, rd, data, illegal);
    modport res (input  valid, rd, data, illegal);
endinterface

// two bypass sources back into decode
interface fwd_if import exec_pkg::*; ();
    logic      ex_valid;
    reg_addr_t ex_rd;
    data_t     ex_data;
    logic      wb_valid;
    reg_addr_t wb_rd;
    data_t     wb_data;

    modport src (output ex_valid, ex_rd, ex_data, wb_valid, wb_rd, wb_data);
    modport dec (input  ex_valid, ex_rd, ex_data, wb_valid, wb_rd, wb_data);
endinterface

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  ex_op_e op,
    input  data_t  opnd1,
    input  data_t  opnd2,
    output data_t  result
);

    logic  sub;
    data_t opnd2_inv;
    data_t sum;
    logic  cout;
    logic  slt;
    logic  sltu;

    // compares run through the subtractor too
    assign sub       = op inside {EX_SUB, EX_SLT, EX_SLTU};
    assign opnd2_inv = sub ? ~opnd2 : opnd2;
    assign {cout, sum} = {1'b0, opnd1} + {1'b0, opnd2_inv} + {32'b0, sub};

    assign slt  = (opnd1[31] & ~opnd2[31])
                | (~(opnd1[31] ^ opnd2[31]) & sum[31]);
    assign sltu = ~cout;   // borrow out

    always_comb
    begin
        case (op)
            EX_ADD,
            EX_SUB:  result = sum;
            EX_SLT:  result = {31'b0, slt};
            EX_SLTU: result = {31'b0, sltu};
            EX_NOR:  result = ~(opnd1 | opnd2);
            EX_AND:  result = opnd1 & opnd2;
            EX_OR:   result = opnd1 | opnd2;
            EX_XOR:  result = opnd1 ^ opnd2;
            EX_SLL:  result = opnd1 << opnd2[4:0];
            EX_SRL:  result = opnd1 >> opnd2[4:0];
            EX_SRA:  result = $signed(opnd1) >>> opnd2[4:0];
            default: result = '0;
        endcase
    end

endmodule

// ==== verilog/mdu.sv ====
`timescale 1ns/1ps

module mdu import exec_pkg::*; (
    input  ex_op_e op,
    input  data_t  opnd1,
    input  data_t  opnd2,
    output data_t  result
);

    logic [63:0]        smul;
    logic [63:0]        umul;
    logic               div_zero;
    logic               div_ovf;
    data_t              dvsr;
    logic signed [31:0] squot;
    logic signed [31:0] srem;
    data_t              uquot;
    data_t              urem;

    assign smul = $signed({{32{opnd1[31]}}, opnd1}) * $signed({{32{opnd2[31]}}, opnd2});
    assign umul = {32'b0, opnd1} * {32'b0, opnd2};

    assign div_zero = (opnd2 == '0);
    assign div_ovf  = (opnd1 == 32'h8000_0000) && (opnd2 == '1);
    assign dvsr     = div_zero ? 32'd1 : opnd2;   // keeps the dividers defined

    assign squot = $signed(opnd1) / $signed(dvsr);
    assign srem  = $signed(opnd1) % $signed(dvsr);   // sign follows dividend
    assign uquot = opnd1 / dvsr;
    assign urem  = opnd1 % dvsr;

    always_comb
    begin
        case (op)
            EX_MUL:   result = smul[31:0];
            EX_MULH:  result = smul[63:32];
            EX_MULHU: result = umul[63:32];
            EX_DIV:   result = div_zero ? '1 : (div_ovf ? 32'h8000_0000 : data_t'(squot));
            EX_MOD:   result = div_zero ? opnd1 : (div_ovf ? '0 : data_t'(srem));
            EX_DIVU:  result = div_zero ? '1 : uquot;
            EX_MODU:  result = div_zero ? opnd1 : urem;
            default:  result = '0;
        endcase
    end

endmodule

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  inst_u     in_inst,
    input  data_t     rs_data1,
    input  data_t     rs_data2,
    output reg_addr_t rs_addr1,
    output reg_addr_t rs_addr2,
    dec_ex_if.dec     ex_bus,
    fwd_if.dec        fwd
);

    ex_op_e op_3r;
    ex_op_e op_ri;
    ex_op_e dec_op;
    logic   is_ri;
    logic   imm_sext;
    data_t  imm;
    data_t  src1;
    data_t  src2;

    // ex pair wins over wb pair, r0 never bypassed
    function automatic data_t pick_operand(
        input reg_addr_t src,
        input data_t     rf_data,
        input logic      ex_valid,
        input reg_addr_t ex_rd,
        input data_t     ex_data,
        input logic      wb_valid,
        input reg_addr_t wb_rd,
        input data_t     wb_data
    );
        if (src == '0)
            return '0;
        if (ex_valid && ex_rd == src)
            return ex_data;
        if (wb_valid && wb_rd == src)
            return wb_data;
        return rf_data;
    endfunction

    always_comb
    begin
        op_3r = EX_NOP;
        case (in_inst.r3.opcode)
            OPC3R_ADD_W:   op_3r = EX_ADD;
            OPC3R_SUB_W:   op_3r = EX_SUB;
            OPC3R_SLT:     op_3r = EX_SLT;
            OPC3R_SLTU:    op_3r = EX_SLTU;
            OPC3R_NOR:     op_3r = EX_NOR;
            OPC3R_AND:     op_3r = EX_AND;
            OPC3R_OR:      op_3r = EX_OR;
            OPC3R_XOR:     op_3r = EX_XOR;
            OPC3R_SLL_W:   op_3r = EX_SLL;
            OPC3R_SRL_W:   op_3r = EX_SRL;
            OPC3R_SRA_W:   op_3r = EX_SRA;
            OPC3R_MUL_W:   op_3r = EX_MUL;
            OPC3R_MULH_W:  op_3r = EX_MULH;
            OPC3R_MULH_WU: op_3r = EX_MULHU;
            OPC3R_DIV_W:   op_3r = EX_DIV;
            OPC3R_MOD_W:   op_3r = EX_MOD;
            OPC3R_DIV_WU:  op_3r = EX_DIVU;
            OPC3R_MOD_WU:  op_3r = EX_MODU;
            default:       op_3r = EX_NOP;
        endcase
    end

    always_comb
    begin
        op_ri    = EX_NOP;
        imm_sext = 1'b1;
        case (in_inst.ri12.opcode)
            OPC2RI12_SLTI:   op_ri = EX_SLT;
            OPC2RI12_SLTUI:  op_ri = EX_SLTU;   // still sign-extended, compared unsigned
            OPC2RI12_ADDI_W: op_ri = EX_ADD;
            OPC2RI12_ANDI:
            begin
                op_ri    = EX_AND;
                imm_sext = 1'b0;
            end
            OPC2RI12_ORI:
            begin
                op_ri    = EX_OR;
                imm_sext = 1'b0;
            end
            OPC2RI12_XORI:
            begin
                op_ri    = EX_XOR;
                imm_sext = 1'b0;
            end
            default:         op_ri = EX_NOP;
        endcase
    end

    // 3R opcodes all have inst[31:22] == 0, so the two views never both hit
    assign is_ri  = (op_ri != EX_NOP);
    assign dec_op = is_ri ? op_ri : op_3r;
    assign imm    = imm_sext ? {{20{in_inst.ri12.imm12[11]}}, in_inst.ri12.imm12}
                             : {20'b0, in_inst.ri12.imm12};

    assign rs_addr1 = in_inst.r3.rj;
    assign rs_addr2 = in_inst.r3.rk;

    assign src1 = pick_operand(rs_addr1, rs_data1, fwd.ex_valid, fwd.ex_rd, fwd.ex_data,
                               fwd.wb_valid, fwd.wb_rd, fwd.wb_data);
    assign src2 = pick_operand(rs_addr2, rs_data2, fwd.ex_valid, fwd.ex_rd, fwd.ex_data,
                               fwd.wb_valid, fwd.wb_rd, fwd.wb_data);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_bus.valid   <= 1'b0;
            ex_bus.op      <= EX_NOP;
            ex_bus.opnd1   <= '0;
            ex_bus.opnd2   <= '0;
            ex_bus.rd      <= '0;
            ex_bus.illegal <= 1'b0;
        end
        else
        begin
            ex_bus.valid   <= in_valid;
            ex_bus.op      <= dec_op;
            ex_bus.opnd1   <= src1;
            ex_bus.opnd2   <= is_ri ? imm : src2;
            ex_bus.rd      <= in_inst.r3.rd;
            ex_bus.illegal <= in_valid && (dec_op == EX_NOP);
        end
    end

    // a legal entry held here comes back on the wb pair next cycle
    a_ex_pair_reaches_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_bus.valid && !ex_bus.illegal && ex_bus.rd != '0)
        |=> (fwd.wb_valid && fwd.wb_rd == $past(ex_bus.rd)
             && fwd.wb_data == $past(fwd.ex_data)));

endmodule

// ==== verilog/int_execute.sv ====
`timescale 1ns/1ps

module int_execute import exec_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    dec_ex_if.ex  dec_bus,
    ex_res_if.ex  res_bus,
    fwd_if.src    fwd
);

    data_t alu_result;
    data_t mdu_result;
    data_t ex_result;

    alu u_alu (
        .op     (dec_bus.op),
        .opnd1  (dec_bus.opnd1),
        .opnd2  (dec_bus.opnd2),
        .result (alu_result)
    );

    mdu u_mdu (
        .op     (dec_bus.op),
        .opnd1  (dec_bus.opnd1),
        .opnd2  (dec_bus.opnd2),
        .result (mdu_result)
    );

    assign ex_result = is_mdu_op(dec_bus.op) ? mdu_result : alu_result;

    // result of the entry in flight, for the next decode
    assign fwd.ex_valid = dec_bus.valid && !dec_bus.illegal;
    assign fwd.ex_rd    = dec_bus.rd;
    assign fwd.ex_data  = ex_result;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            res_bus.valid   <= 1'b0;
            res_bus.rd      <= '0;
            res_bus.data    <= '0;
            res_bus.illegal <= 1'b0;
        end
        else
        begin
            res_bus.valid   <= dec_bus.valid;
            res_bus.rd      <= dec_bus.rd;
            res_bus.data    <= ex_result;
            res_bus.illegal <= dec_bus.illegal;
        end
    end

    // decode hands EX_NOP down, both units must give zero for it
    a_illegal_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (res_bus.valid && res_bus.illegal) |-> (res_bus.data == '0));

endmodule

// ==== verilog/writeback_regfile.sv ====
`timescale 1ns/1ps

module writeback_regfile import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs_addr1,
    input  reg_addr_t rs_addr2,
    output data_t     rs_data1,
    output data_t     rs_data2,
    output logic      out_valid,
    output reg_addr_t out_rd,
    output data_t     out_data,
    output logic      out_illegal,
    ex_res_if.res     res_bus,
    fwd_if.src        fwd
);

    data_t regs [1:31];   // r0 is hardwired
    logic  we;

    assign we = res_bus.valid && !res_bus.illegal && (res_bus.rd != '0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[res_bus.rd] <= res_bus.data;
        end
    end

    assign rs_data1 = (rs_addr1 == '0) ? '0 : regs[rs_addr1];
    assign rs_data2 = (rs_addr2 == '0) ? '0 : regs[rs_addr2];

    assign fwd.wb_valid = we;
    assign fwd.wb_rd    = res_bus.rd;
    assign fwd.wb_data  = res_bus.data;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid   <= 1'b0;
            out_rd      <= '0;
            out_data    <= '0;
            out_illegal <= 1'b0;
        end
        else
        begin
            out_valid   <= res_bus.valid;
            out_rd      <= res_bus.rd;
            out_data    <= res_bus.data;   // r0 writes still reported
            out_illegal <= res_bus.valid && res_bus.illegal;
        end
    end

    // written value reads back on both ports next cycle
    a_write_reads_back: assert property (@(posedge clk) disable iff (!rst_n)
        we |=> ((rs_addr1 != $past(res_bus.rd) || rs_data1 == $past(res_bus.data))
                && (rs_addr2 != $past(res_bus.rd) || rs_data2 == $past(res_bus.data))));

endmodule

// ==== verilog/int_exec_core.sv ====
`timescale 1ns/1ps

module int_exec_core import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [31:0] in_inst,
    output logic        out_valid,
    output reg_addr_t   out_rd,
    output data_t       out_data,
    output logic        out_illegal
);

    reg_addr_t rs_addr1;
    reg_addr_t rs_addr2;
    data_t     rs_data1;
    data_t     rs_data2;

    dec_ex_if u_dec_ex ();
    ex_res_if u_ex_res ();
    fwd_if    u_fwd ();

    inst_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .rs_data1 (rs_data1),
        .rs_data2 (rs_data2),
        .rs_addr1 (rs_addr1),
        .rs_addr2 (rs_addr2),
        .ex_bus   (u_dec_ex.dec),
        .fwd      (u_fwd.dec)
    );

    int_execute u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec_bus (u_dec_ex.ex),
        .res_bus (u_ex_res.ex),
        .fwd     (u_fwd.src)
    );

    writeback_regfile u_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs_addr1    (rs_addr1),
        .rs_addr2    (rs_addr2),
        .rs_data1    (rs_data1),
        .rs_data2    (rs_data2),
        .out_valid   (out_valid),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .out_illegal (out_illegal),
        .res_bus     (u_ex_res.res),
        .fwd         (u_fwd.src)
    );

endmodule

// ==== dv/int_exec_tb.sv ====
`timescale 1ns/1ps

module int_exec_tb;

    localparam time CLK_PERIOD = 8;
    localparam int  N_RANDOM   = 400;
    // loads, alu/mdu sweep, chains, r0/illegal, random mix with at most one gap each, tail
    localparam int  N_SLOTS    = 96 + 800 + 63 + 59 + 2 * N_RANDOM + 4;
    localparam time WATCHDOG   = (N_SLOTS + 20) * CLK_PERIOD + 2 * CLK_PERIOD;

    // 3R minor opcodes inst[21:15], index 0 is add.w, 0..10 alu, 11..17 mdu
    localparam logic [18*7-1:0] R3_OPS = {7'h43, 7'h42, 7'h41, 7'h40, 7'h3A, 7'h39,
                                          7'h38, 7'h30, 7'h2F, 7'h2E, 7'h2B, 7'h2A,
                                          7'h29, 7'h28, 7'h25, 7'h24, 7'h22, 7'h20};
    // inst[31:22], index 0 is slti
    localparam logic [6*10-1:0] RI_OPS = {10'h00F, 10'h00E, 10'h00D, 10'h00A, 10'h009, 10'h008};
    localparam logic [4*12-1:0] IMMS   = {12'h001, 12'hFFF, 12'h7FF, 12'h800};
    localparam int RI_ADDI = 2;
    localparam int RI_ORI  = 4;
    localparam int RI_XORI = 5;
    localparam int R3_ADD  = 0;
    localparam int R3_SUB  = 1;
    localparam int R3_OR   = 6;
    localparam int R3_SLL  = 8;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic        ill;
        logic [31:0] cycle;   // cycle count at which out_valid is due
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] in_inst;
    logic        out_valid;
    logic [4:0]  out_rd;
    logic [31:0] out_data;
    logic        out_illegal;

    logic [31:0] shadow [32];
    logic [31:0] lfsr = 32'h9c0f_7e9a;
    exp_t        exp_q [$];
    exp_t        cur;
    int          cyc = 0;
    int          errors = 0;
    int          n_checked = 0;

    int_exec_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .out_valid   (out_valid),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .out_illegal (out_illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_3r(input int idx, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {10'h000, R3_OPS[idx*7 +: 7], rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri(input int idx, input logic [11:0] imm,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {RI_OPS[idx*10 +: 10], imm, rj, rd};
    endfunction

    function automatic void ref_model(
        input  logic [31:0] inst,
        inout  logic [31:0] regs [32],
        output logic [4:0]  rd,
        output logic [31:0] data,
        output logic        ill
    );
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     imm_s;
        logic [31:0]     imm_z;
        logic [63:0]     prod;
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        rd    = inst[4:0];
        a     = regs[inst[9:5]];
        b     = regs[inst[14:10]];
        sa    = $signed(a);
        sb    = $signed(b);
        ua    = a;
        ub    = b;
        imm_s = {{20{inst[21]}}, inst[21:10]};
        imm_z = {20'h0, inst[21:10]};
        data  = '0;
        ill   = 1'b0;
        case (inst[31:22])
            10'h008: data = {31'b0, $signed(a) < $signed(imm_s)};
            10'h009: data = {31'b0, a < imm_s};
            10'h00A: data = a + imm_s;
            10'h00D: data = a & imm_z;
            10'h00E: data = a | imm_z;
            10'h00F: data = a ^ imm_z;
            10'h000:
            begin
                case (inst[21:15])
                    7'h20: data = a + b;
                    7'h22: data = a - b;
                    7'h24: data = {31'b0, $signed(a) < $signed(b)};
                    7'h25: data = {31'b0, a < b};
                    7'h28: data = ~(a | b);
                    7'h29: data = a & b;
                    7'h2A: data = a | b;
                    7'h2B: data = a ^ b;
                    7'h2E: data = a << b[4:0];
                    7'h2F: data = a >> b[4:0];
                    7'h30: data = $signed(a) >>> b[4:0];
                    7'h38: data = 32'(sa * sb);
                    7'h39:
                    begin
                        prod = sa * sb;
                        data = prod[63:32];
                    end
                    7'h3A:
                    begin
                        prod = ua * ub;
                        data = prod[63:32];
                    end
                    // 64-bit math makes 0x80000000 / -1 wrap to itself with remainder 0
                    7'h40: data = (b == 0) ? 32'hFFFF_FFFF : 32'(sa / sb);
                    7'h41: data = (b == 0) ? a : 32'(sa % sb);
                    7'h42: data = (b == 0) ? 32'hFFFF_FFFF : a / b;
                    7'h43: data = (b == 0) ? a : a % b;
                    default: ill = 1'b1;
                endcase
            end
            default: ill = 1'b1;
        endcase
        if (!ill && rd != 0)
            regs[rd] = data;
    endfunction

    task automatic issue(input logic [31:0] inst);
        exp_t e;
        @(posedge clk);
        in_valid <= 1'b1;
        in_inst  <= inst;
        ref_model(inst, shadow, e.rd, e.data, e.ill);
        e.cycle = cyc + 4;   // sampled next edge, out_valid three edges later
        exp_q.push_back(e);
    endtask

    task automatic idle();
        @(posedge clk);
        in_valid <= 1'b0;
        in_inst  <= rand_bits(32);   // junk while invalid
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
        else
        begin
            errors++;
            $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic load_regs();
        for (int r = 1; r < 32; r++)
        begin
            issue(enc_ri(RI_ADDI, 12'(rand_bits(12)), 5'd0, 5'(r)));
            issue(enc_ri(RI_ORI, 12'(rand_bits(12)), 5'(r), 5'(r)));
            issue(enc_ri(RI_XORI, 12'(rand_bits(12)), 5'(r), 5'(r)));
        end
        issue(enc_ri(RI_ADDI, 12'h9A5, 5'd0, 5'd1));   // sign extended
        issue(enc_ri(RI_ORI, 12'h9A5, 5'd0, 5'd2));    // zero extended
        issue(enc_ri(RI_XORI, 12'hFFF, 5'd1, 5'd3));
    endtask

    task automatic alu_mdu_ops();
        issue(enc_ri(RI_ORI, 12'd1, 5'd0, 5'd1));
        issue(enc_ri(RI_ORI, 12'd31, 5'd0, 5'd2));
        issue(enc_3r(R3_SLL, 5'd2, 5'd1, 5'd3));         // r3 = 0x80000000
        issue(enc_ri(RI_ADDI, 12'hFFF, 5'd0, 5'd4));     // -1
        issue(enc_ri(RI_ADDI, 12'h7FF, 5'd0, 5'd5));
        issue(enc_ri(RI_ADDI, 12'hFFB, 5'd0, 5'd6));     // -5
        issue(enc_ri(RI_ORI, 12'd35, 5'd0, 5'd7));       // shift above 31
        issue(enc_ri(RI_ORI, 12'd0, 5'd0, 5'd8));        // divisor zero
        for (int op = 0; op < 18; op++)
            for (int i = 0; i < 6; i++)
                for (int k = 0; k < 6; k++)
                    issue(enc_3r(op, 5'(3 + k), 5'(3 + i), 5'(16 + (i * 6 + k) % 16)));
        for (int op = 0; op < 6; op++)
            for (int i = 0; i < 6; i++)
                for (int j = 0; j < 4; j++)
                    issue(enc_ri(op, IMMS[j*12 +: 12], 5'(3 + i), 5'(16 + (i * 4 + j) % 16)));
    endtask

    // each entry reads the two previous destinations, one per bypass pair
    task automatic dep_chains();
        logic [4:0] rd;
        logic [4:0] prev;
        logic [4:0] prev2;
        int         op;
        for (int r = 9; r < 12; r++)
            issue(enc_ri(RI_ADDI, 12'(rand_bits(12)), 5'd0, 5'(r)));
        for (int i = 0; i < 60; i++)
        begin
            rd    = 5'(9 + i % 3);
            prev  = 5'(9 + (i + 2) % 3);
            prev2 = 5'(9 + (i + 1) % 3);
            op    = int'(rand_bits(5)) % 18;
            if (i % 3 == 2)
                issue(enc_ri(RI_ADDI, 12'(rand_bits(12)), prev, rd));
            else
                issue(enc_3r(op, prev2, prev, rd));
        end
    endtask

    task automatic r0_and_illegal();
        issue(enc_3r(R3_ADD, 5'd6, 5'd5, 5'd0));
        issue(enc_3r(R3_OR, 5'd0, 5'd0, 5'd12));
        issue(enc_ri(RI_ADDI, 12'h123, 5'd0, 5'd0));
        issue(enc_ri(RI_ORI, 12'h000, 5'd0, 5'd13));
        issue(enc_3r(R3_SUB, 5'd5, 5'd4, 5'd0));
        issue(enc_3r(R3_ADD, 5'd1, 5'd0, 5'd14));
        for (int n = 0; n < 20; n++)
            issue(rand_bits(32) | 32'h8000_0000);
        issue({10'h000, 7'h21, 5'd2, 5'd1, 5'd7});   // hole in the 3R group
        issue({10'h00B, 12'h055, 5'd1, 5'd8});
        for (int r = 1; r < 32; r++)
            issue(enc_3r(R3_OR, 5'd0, 5'(r), 5'(r)));
    endtask

    task automatic random_mix(input int count);
        logic [31:0] w;
        logic [11:0] imm;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
        int          kind;
        int          op;
        for (int n = 0; n < count; n++)
        begin
            if (rand_bits(2) == 0)
                idle();
            kind = int'(rand_bits(4));
            imm  = 12'(rand_bits(12));
            rk   = 5'(rand_bits(5));
            rj   = 5'(rand_bits(5));
            rd   = 5'(rand_bits(5));
            if (kind == 0)
                w = rand_bits(32) | 32'h8000_0000;
            else if (kind < 6)
            begin
                op = int'(rand_bits(3)) % 6;
                w  = enc_ri(op, imm, rj, rd);
            end
            else
            begin
                op = int'(rand_bits(5)) % 18;
                w  = enc_3r(op, rk, rj, rd);
            end
            issue(w);
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk)
    begin
        if (rst_n && out_valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                errors++;
                $display("unexpected result at %0t with nothing issued for it", $time);
            end
            if (exp_q.size() != 0)
            begin
                cur = exp_q.pop_front();
                n_checked++;
                check_field("out_rd", 32'(cur.rd), 32'(out_rd));
                check_field("out_data", cur.data, out_data);
                check_field("out_illegal", 32'(cur.ill), 32'(out_illegal));
                check_field("out_valid cycle", cur.cycle, cyc);
            end
        end
        else if (rst_n && exp_q.size() != 0)
        begin
            assert (exp_q[0].cycle > cyc)
            else
            begin
                errors++;
                $display("result due in cycle %0d never came out", exp_q[0].cycle);
                void'(exp_q.pop_front());
            end
        end
    end

    initial
    begin
        #(WATCHDOG);
        $display("watchdog expired at %0t before all results came out", $time);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        for (int r = 0; r < 32; r++)
            shadow[r] = '0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_inst  = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        load_regs();
        alu_mdu_ops();
        dep_chains();
        r0_and_illegal();
        random_mix(N_RANDOM);
        idle();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);   // catch stray results
        $display("%0d results compared, %0d errors", n_checked, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
verilog/exec_pkg.sv
verilog/stage_if.sv
verilog/alu.sv
verilog/mdu.sv
verilog/inst_decode.sv
verilog/int_execute.sv
verilog/writeback_regfile.sv
verilog/int_exec_core.sv
dv/int_exec_tb.sv

// ==== Bender.yml ====
package:
  name: int_exec_core

sources:
  - verilog/exec_pkg.sv
  - verilog/stage_if.sv
  - verilog/alu.sv
  - verilog/mdu.sv
  - verilog/inst_decode.sv
  - verilog/int_execute.sv
  - verilog/writeback_regfile.sv
  - verilog/int_exec_core.sv
  - target: simulation
    files:
      - dv/int_exec_tb.sv
